// ==== list.f ====
source/rv_front_pkg.sv
source/fetcher.sv
source/field_decoder.sv
source/imm_gen.sv
source/decode_issue.sv
source/fetch_decode_top.sv
test/tb_clock.sv
test/fetch_decode_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and decide pass or fail from the log
verilator --binary --timing -Wno-fatal -f list.f --top-module fetch_decode_tb \
    -Mdir obj_dir -o fetch_decode_sim \
  && ./obj_dir/fetch_decode_sim > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -q "All tests passed!" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== test/fetch_decode_tb.sv ====
`timescale 1ns/1ps

module fetch_decode_tb;
  import rv_front_pkg::*;

  localparam logic [31:0] RESET_PC       = 32'h0000_0080;
  localparam int          ISSUE_CREDITS  = 4;
  localparam int          NUM_RECORDS    = 100;
  localparam int          STALL_AT       = 40;
  localparam int          STALL_CYCLES   = 80;
  localparam int          TIMEOUT_CYCLES = NUM_RECORDS * 400;

  localparam int T_ORDER  = 0;
  localparam int T_FIELDS = 1;
  localparam int T_IMM    = 2;
  localparam int T_MEMREQ = 3;
  localparam int T_CREDIT = 4;

  logic        clk;
  logic        reset;
  logic        mem_valid     = 1'b0;
  logic [31:0] mem_rdata     = '0;
  logic        credit_return = 1'b0;
  mem_req_t    mem_req;
  logic        out_valid;
  decoded_t    out;

  // instruction memory that wraps every 256 bytes
  logic [31:0] mem [64];

  string test_names [5] = '{"record order", "field decode", "immediate",
                            "memory requests", "credit stall"};
  int    errors [5]     = '{default: 0};
  int    check_count    = 0;

  // model state
  logic [31:0] exp_pc       = RESET_PC;
  logic [31:0] exp_req_addr = RESET_PC;
  int          rec_count    = 0;
  int          held         = 0;
  // 0 before the stall, 1 while credits are withheld, 2 after
  int          phase        = 0;
  int          stall_left   = 0;
  int          stall_count  = 0;
  int          cycles       = 0;
  bit          read_pending = 1'b0;
  int          resp_wait    = 0;
  logic [31:0] resp_addr    = '0;

  tb_clock clock_i (
    .clk   (clk),
    .reset (reset)
  );

  fetch_decode_top #(
    .RESET_PC      (RESET_PC),
    .ISSUE_CREDITS (ISSUE_CREDITS)
  ) fetch_decode_top_i (
    .clk           (clk),
    .reset         (reset),
    .mem_req       (mem_req),
    .mem_valid     (mem_valid),
    .mem_rdata     (mem_rdata),
    .credit_return (credit_return),
    .out_valid     (out_valid),
    .out           (out)
  );

  task automatic check_value(input int test_id, input logic [31:0] got,
                             input logic [31:0] exp, input string what);
    check_count++;
    if (got !== exp) begin
      errors[test_id]++;
      $display("[FAIL] %0t: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return mem[addr[7:2]];
  endfunction

  function automatic opclass_e expected_class(input logic [31:0] word);
    opclass_e cls;
    case (word[6:0])
      7'b0110111: cls = OP_LUI;
      7'b0010111: cls = OP_AUIPC;
      7'b1101111: cls = OP_JAL;
      7'b1100111: cls = OP_JALR;
      7'b1100011: cls = OP_BRANCH;
      7'b0000011: cls = OP_LOAD;
      7'b0100011: cls = OP_STORE;
      7'b0010011: cls = OP_IMM;
      7'b0110011: cls = OP_REG;
      7'b0001111: cls = OP_FENCE;
      7'b1110011: cls = OP_SYSTEM;
      default:    cls = OP_ILLEGAL;
    endcase
    return cls;
  endfunction

  function automatic fields_t expected_fields(input logic [31:0] word);
    fields_t  f;
    opclass_e cls;
    cls       = expected_class(word);
    f.opclass = cls;
    f.rd      = (cls inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD, OP_IMM,
                             OP_REG, OP_SYSTEM}) ? word[11:7] : 5'd0;
    f.rs1     = (cls inside {OP_JALR, OP_BRANCH, OP_LOAD, OP_STORE, OP_IMM,
                             OP_REG, OP_SYSTEM}) ? word[19:15] : 5'd0;
    f.rs2     = (cls inside {OP_BRANCH, OP_STORE, OP_REG}) ? word[24:20] : 5'd0;
    f.funct3  = word[14:12];
    f.illegal = (cls == OP_ILLEGAL);
    return f;
  endfunction

  // signed locals sign-extend when cast up to 32 bits
  function automatic logic [31:0] expected_imm(input logic [31:0] word);
    logic signed [11:0] i12;
    logic signed [11:0] s12;
    logic signed [12:0] b13;
    logic signed [20:0] j21;
    logic        [31:0] imm;
    i12 = word[31:20];
    s12 = {word[31:25], word[11:7]};
    b13 = {word[31], word[7], word[30:25], word[11:8], 1'b0};
    j21 = {word[31], word[19:12], word[20], word[30:21], 1'b0};
    case (expected_class(word))
      OP_JALR, OP_LOAD, OP_IMM: imm = 32'(i12);
      OP_STORE:                 imm = 32'(s12);
      OP_BRANCH:                imm = 32'(b13);
      OP_JAL:                   imm = 32'(j21);
      OP_LUI, OP_AUIPC:         imm = {word[31:12], 12'h000};
      default:                  imm = '0;
    endcase
    return imm;
  endfunction

  // mix of every RV32I class plus encodings the front end must reject
  task automatic fill_memory();
    logic [31:0] rnd;
    logic [6:0]  opcode;
    for (int i = 0; i < 64; i++) begin
      rnd = $urandom();
      case ($urandom_range(13, 0))
        0:       opcode = 7'b0110111;
        1:       opcode = 7'b0010111;
        2:       opcode = 7'b1101111;
        3:       opcode = 7'b1100111;
        4:       opcode = 7'b1100011;
        5:       opcode = 7'b0000011;
        6:       opcode = 7'b0100011;
        7:       opcode = 7'b0010011;
        8:       opcode = 7'b0110011;
        9:       opcode = 7'b0001111;
        10:      opcode = 7'b1110011;
        11:      opcode = 7'b0101111;
        12:      opcode = 7'b1010011;
        // compressed encodings whose low bits are never 11
        default: opcode = {rnd[6:2], 1'b0, rnd[0]};
      endcase
      mem[i] = {rnd[31:7], opcode};
    end
  endtask

  task automatic check_record(input decoded_t rec);
    logic [31:0] word;
    fields_t     exp_f;
    string       at;
    word  = mem_word(exp_pc);
    exp_f = expected_fields(word);
    at    = $sformatf(" at pc %h", exp_pc);
    check_value(T_ORDER, rec.pc, exp_pc, "record pc");
    if (phase == 2) begin
      check_value(T_CREDIT, rec.pc, exp_pc, "record pc after credit stall");
    end
    check_value(T_FIELDS, 32'(rec.fields.opclass), 32'(exp_f.opclass), {"opclass", at});
    check_value(T_FIELDS, 32'(rec.fields.rd), 32'(exp_f.rd), {"rd", at});
    check_value(T_FIELDS, 32'(rec.fields.rs1), 32'(exp_f.rs1), {"rs1", at});
    check_value(T_FIELDS, 32'(rec.fields.rs2), 32'(exp_f.rs2), {"rs2", at});
    check_value(T_FIELDS, 32'(rec.fields.funct3), 32'(exp_f.funct3), {"funct3", at});
    check_value(T_FIELDS, 32'(rec.fields.illegal), 32'(exp_f.illegal), {"illegal", at});
    check_value(T_IMM, rec.imm, expected_imm(word), {"immediate", at});
    exp_pc = exp_pc + 32'd4;
    rec_count++;
    held++;
  endtask

  // memory model answering one read at a time 1 to 4 cycles later
  always @(posedge clk) begin
    mem_valid <= 1'b0;
    if (!reset) begin
      if (mem_req.ready) begin
        check_value(T_MEMREQ, 32'(read_pending), 32'd0, "request while a read is pending");
        check_value(T_MEMREQ, 32'(mem_req.instr), 32'd1, "request instr flag");
        check_value(T_MEMREQ, 32'(mem_req.wstrb), 32'd0, "request write strobe");
        check_value(T_MEMREQ, mem_req.addr, exp_req_addr, "request address");
        exp_req_addr = exp_req_addr + 32'd4;
        read_pending = 1'b1;
        resp_wait    = $urandom_range(3, 0);
        resp_addr    = mem_req.addr;
      end
      if (read_pending) begin
        if (resp_wait == 0) begin
          mem_valid    <= 1'b1;
          mem_rdata    <= mem_word(resp_addr);
          read_pending = 1'b0;
        end else begin
          resp_wait = resp_wait - 1;
        end
      end
    end
  end

  // consumer that checks records and hands credits back at random
  always @(posedge clk) begin
    credit_return <= 1'b0;
    if (!reset) begin
      if (out_valid) begin
        check_record(out);
        if (phase == 1) begin
          stall_count++;
        end
      end
      if (phase == 0 && rec_count >= STALL_AT) begin
        phase      = 1;
        stall_left = STALL_CYCLES;
      end else if (phase == 1) begin
        stall_left--;
        if (stall_left == 0) begin
          check_value(T_CREDIT, 32'(stall_count <= ISSUE_CREDITS), 32'd1,
                      "records issued while credits withheld");
          check_value(T_CREDIT, held, ISSUE_CREDITS, "records held at end of stall");
          phase = 2;
        end
      end
      if (phase != 1 && held > 0 && $urandom_range(2, 0) == 0) begin
        credit_return <= 1'b1;
        held--;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: only %0d of %0d records arrived within %0d cycles",
               rec_count, NUM_RECORDS, cycles);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    int failed;
    int total;
    failed = 0;
    total  = 0;
    void'($urandom(32'hd44ec375));
    fill_memory();
    while (rec_count < NUM_RECORDS) begin
      @(posedge clk);
    end
    for (int i = 0; i < 5; i++) begin
      $display("test %0d %-16s %s (%0d errors)", i + 1, test_names[i],
               (errors[i] == 0) ? "ok" : "FAILED", errors[i]);
      if (errors[i] != 0) begin
        failed++;
      end
      total += errors[i];
    end
    $display("summary: 5 tests, %0d failed, %0d checks, %0d errors", failed, check_count, total);
    if (total == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
  parameter int HALF_PERIOD  = 10,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // reset drops on the rising edge that ends RESET_CYCLES cycles
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// ==== source/fetch_decode_top.sv ====
`timescale 1ns/1ps

module fetch_decode_top #(
  parameter logic [rv_front_pkg::XLEN-1:0] RESET_PC      = '0,
  parameter int                            ISSUE_CREDITS = 4
) (
  input  var logic                            clk,
  input  var logic                            reset,
  output var rv_front_pkg::mem_req_t         mem_req,
  input  var logic                            mem_valid,
  input  var logic [rv_front_pkg::XLEN-1:0]  mem_rdata,
  input  var logic                            credit_return,
  output var logic                            out_valid,
  output var rv_front_pkg::decoded_t         out
);
  import rv_front_pkg::*;

  logic            fetcher_valid;
  logic            decoder_ready;
  logic [XLEN-1:0] instr;
  logic [XLEN-1:0] fetcher_pc;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] imm;
  fields_t         fields;

  fetcher fetcher_i (
    .clk           (clk),
    .reset         (reset),
    .decoder_ready (decoder_ready),
    .fetcher_valid (fetcher_valid),
    .pc            (pc),
    .mem_valid     (mem_valid),
    .mem_rdata     (mem_rdata),
    .instr         (instr),
    .fetcher_pc    (fetcher_pc),
    .mem_req       (mem_req)
  );

  // both decoders look at the held word in parallel
  field_decoder field_decoder_i (
    .instr  (instr),
    .fields (fields)
  );

  imm_gen imm_gen_i (
    .instr (instr),
    .imm   (imm)
  );

  decode_issue #(
    .RESET_PC      (RESET_PC),
    .ISSUE_CREDITS (ISSUE_CREDITS)
  ) decode_issue_i (
    .clk           (clk),
    .reset         (reset),
    .fetcher_valid (fetcher_valid),
    .fetcher_pc    (fetcher_pc),
    .decoder_ready (decoder_ready),
    .fields        (fields),
    .imm           (imm),
    .pc            (pc),
    .credit_return (credit_return),
    .out_valid     (out_valid),
    .out           (out)
  );

endmodule

// ==== source/decode_issue.sv ====
`timescale 1ns/1ps

module decode_issue #(
  parameter logic [rv_front_pkg::XLEN-1:0] RESET_PC      = '0,
  parameter int                            ISSUE_CREDITS = 4
) (
  input  var logic                            clk,
  input  var logic                            reset,
  // word from the fetcher
  input  var logic                            fetcher_valid,
  input  var logic [rv_front_pkg::XLEN-1:0]  fetcher_pc,
  output var logic                            decoder_ready,
  // side-by-side decode results
  input  var rv_front_pkg::fields_t          fields,
  input  var logic [rv_front_pkg::XLEN-1:0]  imm,
  // next fetch address
  output var logic [rv_front_pkg::XLEN-1:0]  pc,
  // toward the consumer
  input  var logic                            credit_return,
  output var logic                            out_valid,
  output var rv_front_pkg::decoded_t         out
);
  import rv_front_pkg::*;

  localparam int              CREDIT_W = $clog2(ISSUE_CREDITS + 1);
  localparam logic [XLEN-1:0] PC_STEP  = 4;

  logic [CREDIT_W-1:0] credits;
  logic                accept;
  logic                ready_drop;

  assign accept        = fetcher_valid && decoder_ready && (credits != '0);
  assign decoder_ready = !ready_drop;

  // ready goes low for one cycle after each acceptance to clear the fetcher
  always_ff @(posedge clk) begin
    if (reset) begin
      ready_drop <= 1'b0;
    end else begin
      ready_drop <= accept;
    end
  end

  // issue and return in the same cycle cancel out
  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= CREDIT_W'(ISSUE_CREDITS);
    end else if (accept && !credit_return) begin
      credits <= credits - 1'b1;
    end else if (credit_return && !accept && (credits != CREDIT_W'(ISSUE_CREDITS))) begin
      credits <= credits + 1'b1;
    end
  end

  // sequential fetch only with no branch redirect
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= RESET_PC;
    end else if (accept) begin
      pc <= pc + PC_STEP;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out.pc     <= fetcher_pc;
      out.fields <= fields;
      out.imm    <= imm;
    end
  end

endmodule

// ==== source/imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen (
  input  var logic [rv_front_pkg::XLEN-1:0] instr,
  output var logic [rv_front_pkg::XLEN-1:0] imm
);
  import rv_front_pkg::*;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic            sign;

  assign sign = instr[31];

  // all formats built in parallel and the class picks one
  assign imm_i = {{20{sign}}, instr[31:20]};
  assign imm_s = {{20{sign}}, instr[31:25], instr[11:7]};

  // branch offsets count halfwords so bit 0 is always clear
  assign imm_b = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

  assign imm_u = {instr[31:12], 12'b0};

  assign imm_j = {{11{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    case (opclass_of(instr[6:0]))
      OP_JALR, OP_LOAD, OP_IMM: begin
        imm = imm_i;
      end
      OP_STORE: begin
        imm = imm_s;
      end
      OP_BRANCH: begin
        imm = imm_b;
      end
      OP_LUI, OP_AUIPC: begin
        imm = imm_u;
      end
      OP_JAL: begin
        imm = imm_j;
      end
      // register ops, fence, system and illegal words carry no immediate
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

// ==== source/field_decoder.sv ====
`timescale 1ns/1ps

module field_decoder (
  input  var logic [rv_front_pkg::XLEN-1:0] instr,
  output var rv_front_pkg::fields_t         fields
);
  import rv_front_pkg::*;

  opclass_e cls;
  logic     use_rd;
  logic     use_rs1;
  logic     use_rs2;

  assign cls = opclass_of(instr[6:0]);

  // which register slots each class actually reads or writes
  always_comb begin
    use_rd  = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (cls)
      OP_LUI, OP_AUIPC, OP_JAL: begin
        use_rd = 1'b1;
      end
      OP_JALR, OP_LOAD, OP_IMM, OP_SYSTEM: begin
        use_rd  = 1'b1;
        use_rs1 = 1'b1;
      end
      OP_BRANCH, OP_STORE: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      OP_REG: begin
        use_rd  = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      // fence and illegal words touch no registers
      default: begin
        use_rd  = 1'b0;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
      end
    endcase
  end

  // unused slots read as x0 so later stages see no false hazards
  always_comb begin
    fields.opclass = cls;
    fields.rd      = use_rd  ? instr[11:7]  : 5'd0;
    fields.rs1     = use_rs1 ? instr[19:15] : 5'd0;
    fields.rs2     = use_rs2 ? instr[24:20] : 5'd0;
    fields.funct3  = instr[14:12];
    fields.illegal = (cls == OP_ILLEGAL);
  end

endmodule

// ==== source/fetcher.sv ====
`timescale 1ns/1ps

module fetcher (
  input  var logic                                clk,
  input  var logic                                reset,
  // handshake with the issue stage
  input  var logic                                decoder_ready,
  output var logic                                fetcher_valid,
  // address to fetch next
  input  var logic [rv_front_pkg::XLEN-1:0]      pc,
  // memory response
  input  var logic                                mem_valid,
  input  var logic [rv_front_pkg::XLEN-1:0]      mem_rdata,
  // fetched word and its address
  output var logic [rv_front_pkg::XLEN-1:0]      instr,
  output var logic [rv_front_pkg::XLEN-1:0]      fetcher_pc,
  output var rv_front_pkg::mem_req_t             mem_req
);
  import rv_front_pkg::*;

  logic            req_ready;
  logic            pending;
  logic            idle;
  logic [XLEN-1:0] fetch_addr;

  // no word held and no read in flight
  assign idle = !fetcher_valid && !pending;

  // one-cycle request pulse followed by a wait for the response
  always_ff @(posedge clk) begin
    if (reset) begin
      req_ready <= 1'b0;
      pending   <= 1'b0;
    end else if (idle) begin
      req_ready <= 1'b1;
      pending   <= 1'b1;
    end else begin
      req_ready <= 1'b0;
      if (mem_valid) begin
        pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (idle) begin
      fetch_addr <= pc;
    end
  end

  // valid from the response until the issue stage drops ready
  always_ff @(posedge clk) begin
    if (reset) begin
      fetcher_valid <= 1'b0;
    end else if (mem_valid) begin
      fetcher_valid <= 1'b1;
    end else if (!decoder_ready) begin
      fetcher_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (mem_valid) begin
      instr <= mem_rdata;
    end
  end

  assign fetcher_pc = fetch_addr;

  // reads only so the write strobe stays clear
  always_comb begin
    mem_req.ready = req_ready;
    mem_req.instr = 1'b1;
    mem_req.addr  = fetch_addr;
    mem_req.wstrb = 4'b0000;
  end

endmodule

// ==== source/rv_front_pkg.sv ====
package rv_front_pkg;

  localparam int XLEN = 32;

  // instruction class taken from the major opcode
  typedef enum logic [3:0] {
    OP_LUI     = 4'd0,
    OP_AUIPC   = 4'd1,
    OP_JAL     = 4'd2,
    OP_JALR    = 4'd3,
    OP_BRANCH  = 4'd4,
    OP_LOAD    = 4'd5,
    OP_STORE   = 4'd6,
    OP_IMM     = 4'd7,
    OP_REG     = 4'd8,
    OP_FENCE   = 4'd9,
    OP_SYSTEM  = 4'd10,
    OP_ILLEGAL = 4'd11
  } opclass_e;

  // read request toward instruction memory
  typedef struct packed {
    logic            ready;
    logic            instr;
    logic [XLEN-1:0] addr;
    logic [3:0]      wstrb;
  } mem_req_t;

  typedef struct packed {
    opclass_e   opclass;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] funct3;
    logic       illegal;
  } fields_t;

  // one record handed to the next stage
  typedef struct packed {
    logic [XLEN-1:0] pc;
    fields_t         fields;
    logic [XLEN-1:0] imm;
  } decoded_t;

  // 16-bit encodings and unknown major opcodes map to illegal
  function automatic opclass_e opclass_of(input logic [6:0] opcode);
    opclass_e cls;
    if (opcode[1:0] != 2'b11) begin
      cls = OP_ILLEGAL;
    end else begin
      case (opcode[6:2])
        5'b01101: cls = OP_LUI;
        5'b00101: cls = OP_AUIPC;
        5'b11011: cls = OP_JAL;
        5'b11001: cls = OP_JALR;
        5'b11000: cls = OP_BRANCH;
        5'b00000: cls = OP_LOAD;
        5'b01000: cls = OP_STORE;
        5'b00100: cls = OP_IMM;
        5'b01100: cls = OP_REG;
        5'b00011: cls = OP_FENCE;
        5'b11100: cls = OP_SYSTEM;
        default:  cls = OP_ILLEGAL;
      endcase
    end
    return cls;
  endfunction

endpackage
